/* common/sosPkg.sv */
// ================================================
// Shared types and Morse timing for the SOS beacon
// Every duration is carried in milliseconds and is
// turned into clock cycles by the millisecond timer
// ================================================

package sosPkg;

    // Longest duration is a 300 ms dash
    localparam int MsWidth = 10;

    typedef logic [MsWidth-1:0] msT;

    // Mark lengths
    localparam msT DotMs  = msT'(100);
    localparam msT DashMs = msT'(300);

    // Space lengths
    localparam msT ElemGapMs   = msT'(50);   // Between elements of a letter
    localparam msT LetterGapMs = msT'(150);  // After the last element

    // S and O both have three elements
    localparam int ElemsPerLetter = 3;

    // One letter request from the sequencer to the letter player.
    // The gap between elements is fixed, so only the mark length and
    // the trailing space travel with the request.
    typedef struct packed {
        msT markMs;       // Length of every mark in the letter
        msT lastSpaceMs;  // Space after the final mark
    } letterReqT;

endpackage

/* hw/morse/morseLetter.sv */
// ================================================
// Letter player
// Plays one Morse letter of three equal marks. Each
// mark is followed by the element gap, the last one
// by the requested letter space, then letterDone
// ================================================

`timescale 1ns/1ps

module morseLetter (
    input  logic              CLK,
    input  logic              RSTn,
    input  logic              letterGo,
    input  sosPkg::letterReqT letterReq,
    input  logic              expire,
    output logic              load,
    output sosPkg::msT        loadMs,
    output logic              buzzerN,
    output logic              letterDone
);

    localparam int ElemWidth = $clog2(sosPkg::ElemsPerLetter);

    typedef enum logic [1:0] {
        Idle,
        Mark,
        Space
    } phaseT;

    phaseT                phase;
    logic [ElemWidth-1:0] elemCnt;  // Element now playing
    sosPkg::letterReqT    reqQ;
    logic                 lastElem;
    logic                 finalExpire;

    assign lastElem    = (elemCnt == ElemWidth'(sosPkg::ElemsPerLetter - 1));
    assign finalExpire = expire && (phase == Space) && lastElem;
    assign letterDone  = finalExpire;
    assign load        = letterGo || (expire && (phase != Idle) && !finalExpire);

    // Duration of the phase that starts with this load
    always_comb begin
        if (letterGo) begin
            loadMs = letterReq.markMs;
        end else if (phase == Mark) begin
            loadMs = lastElem ? reqQ.lastSpaceMs : sosPkg::ElemGapMs;
        end else begin
            loadMs = reqQ.markMs;
        end
    end

    always_ff @(posedge CLK) begin
        if (letterGo) begin
            reqQ <= letterReq;
        end
    end

    always_ff @(posedge CLK or negedge RSTn) begin
        if (!RSTn) begin
            phase   <= Idle;
            elemCnt <= '0;
            buzzerN <= 1'b1;
        end else if (letterGo) begin
            phase   <= Mark;
            elemCnt <= '0;
            buzzerN <= 1'b0;  // First mark starts now
        end else if (expire) begin
            case (phase)
                Mark: begin
                    phase   <= Space;
                    buzzerN <= 1'b1;
                end
                Space: begin
                    if (lastElem) begin
                        phase <= Idle;  // Letter finished
                    end else begin
                        phase   <= Mark;
                        elemCnt <= elemCnt + ElemWidth'(1);
                        buzzerN <= 1'b0;
                    end
                end
                default: phase <= Idle;
            endcase
        end
    end

    // The sequencer may only chain a letter onto the final space
    assert property (@(posedge CLK) disable iff (!RSTn)
        letterGo |-> (phase == Idle) || finalExpire);

endmodule

/* hw/morse/sosSequencer.sv */
// ================================================
// SOS message sequencer
// A start pulse in idle plays S, O, S through the
// letter player, chaining each letter on the
// letterDone of the previous one, then pulses done
// ================================================

`timescale 1ns/1ps

module sosSequencer (
    input  logic              CLK,
    input  logic              RSTn,
    input  logic              start,
    input  logic              letterDone,
    output logic              letterGo,
    output sosPkg::letterReqT letterReq,
    output logic              busy,
    output logic              done
);

    typedef enum logic [2:0] {
        Idle,
        FirstS,
        OhLetter,
        LastS,
        Finish
    } stateT;

    stateT state;
    stateT stateNext;

    always_comb begin
        stateNext = state;
        letterGo  = 1'b0;
        case (state)
            Idle: begin
                if (start) begin
                    stateNext = FirstS;
                    letterGo  = 1'b1;
                end
            end
            FirstS: begin
                if (letterDone) begin
                    stateNext = OhLetter;
                    letterGo  = 1'b1;
                end
            end
            OhLetter: begin
                if (letterDone) begin
                    stateNext = LastS;
                    letterGo  = 1'b1;
                end
            end
            LastS: begin
                if (letterDone) begin
                    stateNext = Finish;  // No more letters
                end
            end
            default: stateNext = Idle;   // Finish
        endcase
    end

    // Only the O that follows the first S is made of dashes
    assign letterReq.markMs      = (state == FirstS) ? sosPkg::DashMs : sosPkg::DotMs;
    assign letterReq.lastSpaceMs = sosPkg::LetterGapMs;

    assign done = (state == Finish);
    assign busy = (state == FirstS) || (state == OhLetter) || (state == LastS);

    always_ff @(posedge CLK or negedge RSTn) begin
        if (!RSTn) begin
            state <= Idle;
        end else begin
            state <= stateNext;
        end
    end

    // Letters finish only while a message is playing
    assert property (@(posedge CLK) disable iff (!RSTn)
        letterDone |-> busy);

endmodule

/* hw/msTimer.sv */
// ================================================
// Millisecond phase timer
// A load pulse starts a phase of loadMs milliseconds
// and expire pulses in its last cycle. A new load
// in that cycle chains the next phase with no gap
// ================================================

`timescale 1ns/1ps

module msTimer #(
    parameter int TicksPerMs = 50000
) (
    input  logic       CLK,
    input  logic       RSTn,
    input  logic       load,
    input  sosPkg::msT loadMs,
    output logic       expire
);

    localparam int TickWidth = (TicksPerMs > 1) ? $clog2(TicksPerMs) : 1;

    logic [TickWidth-1:0] tickCnt;  // Cycles within the current ms
    sosPkg::msT           msLeft;   // Milliseconds still to run
    logic                 active;
    logic                 lastTick;

    assign lastTick = (tickCnt == TickWidth'(TicksPerMs - 1));
    assign expire   = active && lastTick && (msLeft == sosPkg::msT'(1));

    always_ff @(posedge CLK or negedge RSTn) begin
        if (!RSTn) begin
            active  <= 1'b0;
            tickCnt <= '0;
            msLeft  <= '0;
        end else if (load) begin
            active  <= 1'b1;  // Restart both counters
            tickCnt <= '0;
            msLeft  <= loadMs;
        end else if (expire) begin
            active  <= 1'b0;
            tickCnt <= '0;
        end else if (active) begin
            if (lastTick) begin
                tickCnt <= '0;
                msLeft  <= msLeft - sosPkg::msT'(1);
            end else begin
                tickCnt <= tickCnt + TickWidth'(1);
            end
        end
    end

    // A new phase starts only from idle or in the last cycle of the current one
    assert property (@(posedge CLK) disable iff (!RSTn)
        load |-> !active || expire);

    // A zero length phase would never expire
    assert property (@(posedge CLK) disable iff (!RSTn)
        load |-> loadMs != '0);

endmodule

/* hw/sosBeacon.sv */
// ================================================
// SOS distress beacon top level
// One start pulse plays S-O-S once on the active
// low buzzer pin and ends with a done pulse.
// TicksPerMs is the clock cycle count of one ms
// ================================================

`timescale 1ns/1ps

module sosBeacon #(
    parameter int TicksPerMs = 50000
) (
    input  logic CLK,
    input  logic RSTn,
    input  logic start,
    output logic buzzerN,
    output logic busy,
    output logic done
);

    logic              letterGo;
    logic              letterDone;
    sosPkg::letterReqT letterReq;
    logic              load;
    sosPkg::msT        loadMs;
    logic              expire;

    sosSequencer uSequencer (
        .CLK        (CLK),
        .RSTn       (RSTn),
        .start      (start),
        .letterDone (letterDone),
        .letterGo   (letterGo),
        .letterReq  (letterReq),
        .busy       (busy),
        .done       (done)
    );

    morseLetter uLetter (
        .CLK        (CLK),
        .RSTn       (RSTn),
        .letterGo   (letterGo),
        .letterReq  (letterReq),
        .expire     (expire),
        .load       (load),
        .loadMs     (loadMs),
        .buzzerN    (buzzerN),
        .letterDone (letterDone)
    );

    msTimer #(
        .TicksPerMs (TicksPerMs)
    ) uTimer (
        .CLK    (CLK),
        .RSTn   (RSTn),
        .load   (load),
        .loadMs (loadMs),
        .expire (expire)
    );

endmodule

/* run.sh */
#!/usr/bin/env bash
# Build and run the SOS beacon testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
    --timescale 1ns/1ps \
    --top-module sosBeaconTb \
    -Mdir obj_dir \
    -o sosBeaconSim \
    -f verilog.f

./obj_dir/sosBeaconSim

/* verification/clockGen.sv */
// ==================================================
// Testbench clock and reset source
// Free running clock, reset held low for a number
// of cycles and released just after a rising edge
// ==================================================

`timescale 1ns/1ps

module clockGen #(
    parameter int PeriodNs    = 8,
    parameter int ResetCycles = 10
) (
    output logic CLK,
    output logic RSTn
);

    initial begin
        CLK = 1'b0;
        forever #(PeriodNs / 2) CLK = ~CLK;
    end

    initial begin
        RSTn = 1'b0;
        repeat (ResetCycles) @(posedge CLK);
        #1 RSTn = 1'b1;
    end

endmodule

/* verification/sosBeaconTb.sv */
// ==================================================
// Testbench for the SOS beacon
// Plays eight messages with random idle gaps and
// random extra starts while busy, and checks every
// buzzer run, busy and done against a cycle model
// ==================================================

`timescale 1ns/1ps

module sosBeaconTb;

    localparam int TicksPerMs  = 4;
    localparam int Messages    = 8;
    localparam int MaxGap      = 63;
    localparam int ResetCycles = 10;
    // About 9100 cycles per message plus idle gaps and reset, rounded up
    localparam int TimeoutCycles =
        ((Messages * 9100 + Messages * (MaxGap + 1) + ResetCycles) / 10000 + 1) * 10000;

    logic CLK;
    logic RSTn;
    logic start;
    logic buzzerN;
    logic busy;
    logic done;

    int seed;
    int cycleCount = 0;
    int doneCount  = 0;
    int expRuns[$];  // Alternating low and high run lengths in cycles

    clockGen #(
        .PeriodNs    (8),
        .ResetCycles (ResetCycles)
    ) uClock (
        .CLK  (CLK),
        .RSTn (RSTn)
    );

    sosBeacon #(
        .TicksPerMs (TicksPerMs)
    ) uut (
        .CLK     (CLK),
        .RSTn    (RSTn),
        .start   (start),
        .buzzerN (buzzerN),
        .busy    (busy),
        .done    (done)
    );

    task automatic checkValue(input string name, input int expected, input int actual);
        if (expected != actual) begin
            $display("error: %s expected %0d actual %0d", name, expected, actual);
            $display("Result: FAILED");
            $fatal(1, "Mismatch in %s", name);
        end
    endtask

    // Dot letter, dash letter, dot letter
    task automatic buildModel();
        int markCycles;
        int total;
        total = 0;
        expRuns.delete();
        for (int letter = 0; letter < 3; letter++) begin
            markCycles = (letter == 1) ? int'(sosPkg::DashMs) * TicksPerMs
                                       : int'(sosPkg::DotMs) * TicksPerMs;
            for (int elem = 0; elem < sosPkg::ElemsPerLetter; elem++) begin
                expRuns.push_back(markCycles);
                if (elem == sosPkg::ElemsPerLetter - 1) begin
                    expRuns.push_back(int'(sosPkg::LetterGapMs) * TicksPerMs);
                end else begin
                    expRuns.push_back(int'(sosPkg::ElemGapMs) * TicksPerMs);
                end
            end
        end
        foreach (expRuns[i]) total += expRuns[i];
        checkValue("model cycles", 2250 * TicksPerMs, total);
    endtask

    // Drive just after the rising edge, sample at the falling edge
    task automatic nextCycle(input logic startVal);
        @(posedge CLK);
        #1 start = startVal;
        @(negedge CLK);
    endtask

    task automatic checkIdle(input string name);
        checkValue({name, " buzzerN"}, 1, int'(buzzerN));
        checkValue({name, " busy"}, 0, int'(busy));
        checkValue({name, " done"}, 0, int'(done));
    endtask

    task automatic playMessage(input int msgIdx);
        string tag;
        int    runIdx;
        int    runLen;
        logic  level;
        logic  extra;
        tag    = $sformatf("message %0d", msgIdx);
        runIdx = 0;
        runLen = 0;
        level  = 1'b0;           // First run is a mark
        nextCycle(1'b1);
        checkIdle({tag, " before start"});
        extra = (($random(seed) & 255) == 0);
        nextCycle(extra);        // Start taken at this edge
        while (!done) begin
            checkValue({tag, " busy"}, 1, int'(busy));
            if (buzzerN == level) begin
                runLen++;
            end else begin
                checkValue($sformatf("%s run %0d length", tag, runIdx), expRuns[runIdx], runLen);
                runIdx++;
                if (runIdx >= expRuns.size()) begin
                    checkValue({tag, " run index"}, expRuns.size() - 1, runIdx);
                end
                level  = buzzerN;
                runLen = 1;
            end
            extra = (($random(seed) & 255) == 0);  // Ignored while busy
            nextCycle(extra);
        end
        // Done cycle follows the final letter space
        checkValue({tag, " runs at done"}, expRuns.size() - 1, runIdx);
        checkValue({tag, " final space"}, expRuns[expRuns.size() - 1], runLen);
        checkValue({tag, " buzzerN at done"}, 1, int'(buzzerN));
        checkValue({tag, " busy at done"}, 0, int'(busy));
        nextCycle(1'b0);
        checkIdle({tag, " after done"});
        checkValue({tag, " done pulses"}, msgIdx + 1, doneCount);
    endtask

    always @(posedge CLK) begin
        if (RSTn && done) begin
            doneCount++;
        end
    end

    always @(posedge CLK) begin
        cycleCount++;
        if (cycleCount >= TimeoutCycles) begin
            $display("Result: FAILED");
            $fatal(1, "Timeout: run did not finish within %0d cycles", TimeoutCycles);
        end
    end

    initial begin
        int gap;
        start = 1'b0;
        seed  = 57449;
        buildModel();
        while (RSTn !== 1'b1) begin
            @(negedge CLK);
            checkIdle("reset");
        end
        repeat (3) begin
            nextCycle(1'b0);
            checkIdle("after reset");
        end
        for (int msg = 0; msg < Messages; msg++) begin
            gap = $random(seed) & MaxGap;
            repeat (gap) begin
                nextCycle(1'b0);
                checkIdle("idle gap");
            end
            playMessage(msg);
        end
        repeat (4) begin
            nextCycle(1'b0);
            checkIdle("after last message");
        end
        checkValue("total done pulses", Messages, doneCount);
        $display("Result: PASSED");
        $finish;
    end

endmodule

/* verilog.f */
common/sosPkg.sv
hw/msTimer.sv
hw/morse/morseLetter.sv
hw/morse/sosSequencer.sv
hw/sosBeacon.sv
verification/clockGen.sv
verification/sosBeaconTb.sv
